//--- hdl/ninjin_pkg.sv
package ninjin_pkg;

  // ======================================================================
  // Widths
  // ======================================================================
  localparam int DWIDTH      = 16;
  localparam int BWIDTH      = 32;
  localparam int IMGSIZE     = 8;
  localparam int NETSIZE     = 9;
  localparam int LWIDTH      = 8;
  localparam int ACCWIDTH    = 40;
  localparam int FRAC_BITS   = 8;
  localparam int HADDR_WIDTH = 16;

  // Top two bits of the host address
  localparam logic [1:0] REGION_REG  = 2'd0;
  localparam logic [1:0] REGION_IMG  = 2'd1;
  localparam logic [1:0] REGION_NET  = 2'd2;
  localparam logic [1:0] REGION_NONE = 2'd3;

  // ======================================================================
  // Register map
  // ======================================================================
  localparam logic [3:0] REG_CTRL       = 4'd0;
  localparam logic [3:0] REG_IN_OFFSET  = 4'd1;
  localparam logic [3:0] REG_OUT_OFFSET = 4'd2;
  localparam logic [3:0] REG_NET_OFFSET = 4'd3;
  localparam logic [3:0] REG_BASE       = 4'd4;
  localparam logic [3:0] REG_FLAGS      = 4'd5;
  localparam logic [3:0] REG_STATUS     = 4'd6;

  localparam int BIAS_EN_BIT = 31;
  localparam int RELU_EN_BIT = 30;

  typedef struct packed {
    logic [1:0] region;
    logic [9:0] unused;
    logic [3:0] index;
  } host_reg_view_t;

  typedef struct packed {
    logic [1:0]  region;
    logic [13:0] index;
  } host_mem_view_t;

  // Same address word, seen as a register or as a memory word
  typedef union packed {
    host_reg_view_t r;
    host_mem_view_t m;
  } host_addr_t;

endpackage

//--- hdl/ninjin_host_bridge.sv
module ninjin_host_bridge (
  input  logic                           clk,
  input  logic                           xrst,
  input  logic                           cmd_valid,
  input  logic                           cmd_we,
  input  ninjin_pkg::host_addr_t         cmd_addr,
  input  logic [ninjin_pkg::BWIDTH-1:0]  cmd_wdata,
  output logic                           cmd_ready,
  output logic                           rsp_valid,
  output logic [ninjin_pkg::BWIDTH-1:0]  rsp_data,
  input  logic                           rsp_ready,
  output logic                           reg_wr,
  output logic                           reg_rd,
  output logic [3:0]                     reg_index,
  output logic [ninjin_pkg::BWIDTH-1:0]  reg_wdata,
  input  logic [ninjin_pkg::BWIDTH-1:0]  reg_rdata,
  output logic                           img_req,
  output logic                           img_we,
  output logic [ninjin_pkg::IMGSIZE-1:0] img_addr,
  output logic [ninjin_pkg::DWIDTH-1:0]  img_wdata,
  input  logic                           img_ready,
  input  logic [ninjin_pkg::DWIDTH-1:0]  img_rdata,
  output logic                           net_req,
  output logic                           net_we,
  output logic [ninjin_pkg::NETSIZE-1:0] net_addr,
  output logic [ninjin_pkg::DWIDTH-1:0]  net_wdata,
  input  logic                           net_ready,
  input  logic [ninjin_pkg::DWIDTH-1:0]  net_rdata
);

  logic       alive;
  logic [1:0] region;
  logic       tgt_ready;
  logic       accept;
  logic [1:0] rd_src;

  assign region = cmd_addr.r.region;

  always_comb begin
    case (region)
      ninjin_pkg::REGION_IMG: tgt_ready = img_ready;
      ninjin_pkg::REGION_NET: tgt_ready = net_ready;
      default:                tgt_ready = 1'b1;
    endcase
  end

  // One read outstanding at most
  assign cmd_ready = alive && !rsp_valid && tgt_ready;
  assign accept    = cmd_valid && cmd_ready;

  assign reg_wr    = accept && cmd_we && region == ninjin_pkg::REGION_REG;
  assign reg_rd    = accept && !cmd_we && region == ninjin_pkg::REGION_REG;
  assign reg_index = cmd_addr.r.index;
  assign reg_wdata = cmd_wdata;

  assign img_req   = accept && region == ninjin_pkg::REGION_IMG;
  assign img_we    = cmd_we;
  assign img_addr  = cmd_addr.m.index[ninjin_pkg::IMGSIZE-1:0];
  assign img_wdata = cmd_wdata[ninjin_pkg::DWIDTH-1:0];

  assign net_req   = accept && region == ninjin_pkg::REGION_NET;
  assign net_we    = cmd_we;
  assign net_addr  = cmd_addr.m.index[ninjin_pkg::NETSIZE-1:0];
  assign net_wdata = cmd_wdata[ninjin_pkg::DWIDTH-1:0];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      alive     <= 1'b0;
      rsp_valid <= 1'b0;
      rd_src    <= ninjin_pkg::REGION_NONE;
    end else begin
      alive <= 1'b1;
      if (accept && !cmd_we) begin
        rsp_valid <= 1'b1;
        rd_src    <= region;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  // Sources only update on a host read, so the mux output holds
  always_comb begin
    case (rd_src)
      ninjin_pkg::REGION_REG: rsp_data = reg_rdata;
      ninjin_pkg::REGION_IMG: rsp_data = ninjin_pkg::BWIDTH'($signed(img_rdata));
      ninjin_pkg::REGION_NET: rsp_data = ninjin_pkg::BWIDTH'($signed(net_rdata));
      default:                rsp_data = '0;
    endcase
  end

  a_rsp_hold: assert property (@(posedge clk) disable iff (!xrst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

//--- hdl/ninjin_regs.sv
module ninjin_regs (
  input  logic                           clk,
  input  logic                           xrst,
  input  logic                           reg_wr,
  input  logic                           reg_rd,
  input  logic [3:0]                     reg_index,
  input  logic [ninjin_pkg::BWIDTH-1:0]  reg_wdata,
  output logic [ninjin_pkg::BWIDTH-1:0]  reg_rdata,
  input  logic                           busy,
  input  logic                           done,
  output logic                           start,
  output logic [ninjin_pkg::IMGSIZE-1:0] in_offset,
  output logic [ninjin_pkg::IMGSIZE-1:0] out_offset,
  output logic [ninjin_pkg::NETSIZE-1:0] net_offset,
  output logic [ninjin_pkg::LWIDTH-1:0]  total_in,
  output logic [ninjin_pkg::LWIDTH-1:0]  total_out,
  output logic                           bias_en,
  output logic                           relu_en
);

  logic [ninjin_pkg::BWIDTH-1:0] in_off_q;
  logic [ninjin_pkg::BWIDTH-1:0] out_off_q;
  logic [ninjin_pkg::BWIDTH-1:0] net_off_q;
  logic [ninjin_pkg::BWIDTH-1:0] base_q;
  logic [ninjin_pkg::BWIDTH-1:0] flags_q;
  logic                          ack;
  logic                          start_req;

  // Start is dropped while a layer is running
  assign start_req = reg_wr && reg_index == ninjin_pkg::REG_CTRL && reg_wdata[0]
                     && !busy && !start;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      in_off_q  <= '0;
      out_off_q <= '0;
      net_off_q <= '0;
      base_q    <= '0;
      flags_q   <= '0;
      start     <= 1'b0;
      ack       <= 1'b0;
    end else begin
      start <= start_req;
      if (start_req)
        ack <= 1'b0;
      else if (done)
        ack <= 1'b1;
      if (reg_wr) begin
        case (reg_index)
          ninjin_pkg::REG_IN_OFFSET:  in_off_q  <= reg_wdata;
          ninjin_pkg::REG_OUT_OFFSET: out_off_q <= reg_wdata;
          ninjin_pkg::REG_NET_OFFSET: net_off_q <= reg_wdata;
          ninjin_pkg::REG_BASE:       base_q    <= reg_wdata;
          ninjin_pkg::REG_FLAGS:      flags_q   <= reg_wdata;
          default: ;
        endcase
      end
    end
  end

  // Busy also covers the start cycle, ack the done cycle
  always_ff @(posedge clk) begin
    if (reg_rd) begin
      case (reg_index)
        ninjin_pkg::REG_IN_OFFSET:  reg_rdata <= in_off_q;
        ninjin_pkg::REG_OUT_OFFSET: reg_rdata <= out_off_q;
        ninjin_pkg::REG_NET_OFFSET: reg_rdata <= net_off_q;
        ninjin_pkg::REG_BASE:       reg_rdata <= base_q;
        ninjin_pkg::REG_FLAGS:      reg_rdata <= flags_q;
        ninjin_pkg::REG_STATUS:     reg_rdata <= {{(ninjin_pkg::BWIDTH-2){1'b0}},
                                                  busy || start, ack || done};
        default:                    reg_rdata <= '0;
      endcase
    end
  end

  assign in_offset  = in_off_q[ninjin_pkg::IMGSIZE-1:0];
  assign out_offset = out_off_q[ninjin_pkg::IMGSIZE-1:0];
  assign net_offset = net_off_q[ninjin_pkg::NETSIZE-1:0];
  assign total_in   = base_q[ninjin_pkg::LWIDTH-1:0];
  assign total_out  = base_q[2*ninjin_pkg::LWIDTH-1:ninjin_pkg::LWIDTH];
  assign bias_en    = flags_q[ninjin_pkg::BIAS_EN_BIT];
  assign relu_en    = flags_q[ninjin_pkg::RELU_EN_BIT];

endmodule

//--- hdl/ninjin_img_buf.sv
module ninjin_img_buf (
  input  logic                           clk,
  input  logic                           busy,
  input  logic                           host_req,
  input  logic                           host_we,
  input  logic [ninjin_pkg::IMGSIZE-1:0] host_addr,
  input  logic [ninjin_pkg::DWIDTH-1:0]  host_wdata,
  output logic                           host_ready,
  output logic [ninjin_pkg::DWIDTH-1:0]  host_rdata,
  input  logic                           eng_we,
  input  logic [ninjin_pkg::IMGSIZE-1:0] eng_addr,
  input  logic [ninjin_pkg::DWIDTH-1:0]  eng_wdata,
  output logic [ninjin_pkg::DWIDTH-1:0]  eng_rdata
);

  logic [ninjin_pkg::DWIDTH-1:0]  mem [0:(1<<ninjin_pkg::IMGSIZE)-1];
  logic [ninjin_pkg::IMGSIZE-1:0] addr;
  logic [ninjin_pkg::DWIDTH-1:0]  wdata;
  logic                           we;

  // Engine owns the port for the whole run
  assign host_ready = !busy;
  assign addr       = busy ? eng_addr : host_addr;
  assign wdata      = busy ? eng_wdata : host_wdata;
  assign we         = busy ? eng_we : host_req && host_we;

  always_ff @(posedge clk) begin
    if (we)
      mem[addr] <= wdata;
    if (busy)
      eng_rdata <= mem[addr];
    else if (host_req && !host_we)
      host_rdata <= mem[addr];
  end

  a_no_host_in_run: assert property (@(posedge clk) host_req |-> !busy);

endmodule

//--- hdl/gobou_net_mem.sv
module gobou_net_mem (
  input  logic                           clk,
  input  logic                           busy,
  input  logic                           host_req,
  input  logic                           host_we,
  input  logic [ninjin_pkg::NETSIZE-1:0] host_addr,
  input  logic [ninjin_pkg::DWIDTH-1:0]  host_wdata,
  output logic                           host_ready,
  output logic [ninjin_pkg::DWIDTH-1:0]  host_rdata,
  input  logic [ninjin_pkg::NETSIZE-1:0] eng_addr,
  output logic [ninjin_pkg::DWIDTH-1:0]  eng_rdata
);

  // Weights first, then one bias per output
  logic [ninjin_pkg::DWIDTH-1:0]  mem [0:(1<<ninjin_pkg::NETSIZE)-1];
  logic [ninjin_pkg::NETSIZE-1:0] addr;

  assign host_ready = !busy;
  assign addr       = busy ? eng_addr : host_addr;

  always_ff @(posedge clk) begin
    if (!busy && host_req && host_we)
      mem[addr] <= host_wdata;
    if (busy)
      eng_rdata <= mem[addr];
    else if (host_req && !host_we)
      host_rdata <= mem[addr];
  end

endmodule

//--- hdl/gobou_core.sv
module gobou_core (
  input  logic                           clk,
  input  logic                           xrst,
  input  logic                           start,
  input  logic [ninjin_pkg::IMGSIZE-1:0] in_offset,
  input  logic [ninjin_pkg::IMGSIZE-1:0] out_offset,
  input  logic [ninjin_pkg::NETSIZE-1:0] net_offset,
  input  logic [ninjin_pkg::LWIDTH-1:0]  total_in,
  input  logic [ninjin_pkg::LWIDTH-1:0]  total_out,
  input  logic                           bias_en,
  input  logic                           relu_en,
  output logic                           busy,
  output logic                           done,
  output logic                           img_we,
  output logic [ninjin_pkg::IMGSIZE-1:0] img_addr,
  output logic [ninjin_pkg::DWIDTH-1:0]  img_wdata,
  input  logic [ninjin_pkg::DWIDTH-1:0]  img_rdata,
  output logic [ninjin_pkg::NETSIZE-1:0] net_addr,
  input  logic [ninjin_pkg::DWIDTH-1:0]  net_rdata
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_ISSUE,
    S_BIAS,
    S_DRAIN,
    S_WRITE
  } state_t;

  state_t                                 state;
  logic [ninjin_pkg::LWIDTH-1:0]          cnt_o;
  logic [ninjin_pkg::LWIDTH-1:0]          cnt_i;
  logic [ninjin_pkg::NETSIZE-1:0]         net_ptr;
  logic [ninjin_pkg::NETSIZE-1:0]         bias_addr;
  logic                                   rd_v;
  logic                                   mul_v;
  logic                                   acc_v;
  logic                                   bias_v;
  logic signed [2*ninjin_pkg::DWIDTH-1:0] prod;
  logic signed [ninjin_pkg::ACCWIDTH-1:0] acc;
  logic signed [ninjin_pkg::DWIDTH-1:0]   bias_q;
  logic signed [ninjin_pkg::DWIDTH-1:0]   bias_add;
  logic signed [ninjin_pkg::ACCWIDTH-1:0] sum;
  logic signed [ninjin_pkg::ACCWIDTH-1:0] result;

  // ======================================================================
  // Sequencer
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state   <= S_IDLE;
      cnt_o   <= '0;
      cnt_i   <= '0;
      net_ptr <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE:
          if (start) begin
            state   <= S_ISSUE;
            cnt_o   <= '0;
            cnt_i   <= '0;
            net_ptr <= net_offset;
          end
        S_ISSUE: begin
          net_ptr <= net_ptr + 1'b1;
          cnt_i   <= cnt_i + 1'b1;
          if (cnt_i == total_in - 1'b1)
            state <= S_BIAS;
        end
        S_BIAS:
          state <= S_DRAIN;
        S_DRAIN:
          state <= S_WRITE;
        S_WRITE: begin
          cnt_i <= '0;
          cnt_o <= cnt_o + 1'b1;
          if (cnt_o == total_out - 1'b1) begin
            state <= S_IDLE;
            done  <= 1'b1;
          end else begin
            state <= S_ISSUE;
          end
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  assign busy      = state != S_IDLE;
  assign rd_v      = state == S_ISSUE;
  assign bias_addr = ninjin_pkg::NETSIZE'(net_offset + total_out * total_in + cnt_o);

  assign img_we    = state == S_WRITE;
  assign img_addr  = img_we ? out_offset + cnt_o : in_offset + cnt_i;
  assign net_addr  = state == S_BIAS ? bias_addr : net_ptr;

  // ======================================================================
  // Multiply-accumulate
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      mul_v  <= 1'b0;
      acc_v  <= 1'b0;
      bias_v <= 1'b0;
    end else begin
      mul_v  <= rd_v;
      acc_v  <= mul_v;
      bias_v <= state == S_BIAS;
    end
  end

  // Data returns one cycle after issue, the product one cycle later
  always_ff @(posedge clk) begin
    prod <= $signed(img_rdata) * $signed(net_rdata);
    if (bias_v)
      bias_q <= $signed(net_rdata);
    if (state == S_IDLE || state == S_WRITE)
      acc <= '0;
    else if (acc_v)
      acc <= acc + prod;
  end

  assign bias_add  = bias_en ? bias_q : '0;
  assign sum       = (acc >>> ninjin_pkg::FRAC_BITS) + bias_add;
  assign result    = (relu_en && sum < 0) ? '0 : sum;
  assign img_wdata = result[ninjin_pkg::DWIDTH-1:0];

  a_write_drained: assert property (@(posedge clk) disable iff (!xrst)
    img_we |-> !mul_v && !acc_v);

endmodule

//--- hdl/ninjin_top.sv
module ninjin_top (
  input  logic                          clk,
  input  logic                          xrst,
  input  logic                          cmd_valid,
  input  logic                          cmd_we,
  input  ninjin_pkg::host_addr_t        cmd_addr,
  input  logic [ninjin_pkg::BWIDTH-1:0] cmd_wdata,
  output logic                          cmd_ready,
  output logic                          rsp_valid,
  output logic [ninjin_pkg::BWIDTH-1:0] rsp_data,
  input  logic                          rsp_ready
);

  logic                           reg_wr;
  logic                           reg_rd;
  logic [3:0]                     reg_index;
  logic [ninjin_pkg::BWIDTH-1:0]  reg_wdata;
  logic [ninjin_pkg::BWIDTH-1:0]  reg_rdata;

  logic                           img_req;
  logic                           img_we;
  logic [ninjin_pkg::IMGSIZE-1:0] img_addr;
  logic [ninjin_pkg::DWIDTH-1:0]  img_wdata;
  logic                           img_ready;
  logic [ninjin_pkg::DWIDTH-1:0]  img_rdata;
  logic                           net_req;
  logic                           net_we;
  logic [ninjin_pkg::NETSIZE-1:0] net_addr;
  logic [ninjin_pkg::DWIDTH-1:0]  net_wdata;
  logic                           net_ready;
  logic [ninjin_pkg::DWIDTH-1:0]  net_rdata;

  // Engine side
  logic                           start;
  logic                           busy;
  logic                           done;
  logic [ninjin_pkg::IMGSIZE-1:0] in_offset;
  logic [ninjin_pkg::IMGSIZE-1:0] out_offset;
  logic [ninjin_pkg::NETSIZE-1:0] net_offset;
  logic [ninjin_pkg::LWIDTH-1:0]  total_in;
  logic [ninjin_pkg::LWIDTH-1:0]  total_out;
  logic                           bias_en;
  logic                           relu_en;
  logic                           eng_img_we;
  logic [ninjin_pkg::IMGSIZE-1:0] eng_img_addr;
  logic [ninjin_pkg::DWIDTH-1:0]  eng_img_wdata;
  logic [ninjin_pkg::DWIDTH-1:0]  eng_img_rdata;
  logic [ninjin_pkg::NETSIZE-1:0] eng_net_addr;
  logic [ninjin_pkg::DWIDTH-1:0]  eng_net_rdata;

  ninjin_host_bridge ninjin_host_bridge_inst (
    .clk        (clk),
    .xrst       (xrst),
    .cmd_valid  (cmd_valid),
    .cmd_we     (cmd_we),
    .cmd_addr   (cmd_addr),
    .cmd_wdata  (cmd_wdata),
    .cmd_ready  (cmd_ready),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_ready  (rsp_ready),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_index  (reg_index),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .img_req    (img_req),
    .img_we     (img_we),
    .img_addr   (img_addr),
    .img_wdata  (img_wdata),
    .img_ready  (img_ready),
    .img_rdata  (img_rdata),
    .net_req    (net_req),
    .net_we     (net_we),
    .net_addr   (net_addr),
    .net_wdata  (net_wdata),
    .net_ready  (net_ready),
    .net_rdata  (net_rdata)
  );

  ninjin_regs ninjin_regs_inst (
    .clk        (clk),
    .xrst       (xrst),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_index  (reg_index),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .busy       (busy),
    .done       (done),
    .start      (start),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_in   (total_in),
    .total_out  (total_out),
    .bias_en    (bias_en),
    .relu_en    (relu_en)
  );

  ninjin_img_buf ninjin_img_buf_inst (
    .clk        (clk),
    .busy       (busy),
    .host_req   (img_req),
    .host_we    (img_we),
    .host_addr  (img_addr),
    .host_wdata (img_wdata),
    .host_ready (img_ready),
    .host_rdata (img_rdata),
    .eng_we     (eng_img_we),
    .eng_addr   (eng_img_addr),
    .eng_wdata  (eng_img_wdata),
    .eng_rdata  (eng_img_rdata)
  );

  gobou_net_mem gobou_net_mem_inst (
    .clk        (clk),
    .busy       (busy),
    .host_req   (net_req),
    .host_we    (net_we),
    .host_addr  (net_addr),
    .host_wdata (net_wdata),
    .host_ready (net_ready),
    .host_rdata (net_rdata),
    .eng_addr   (eng_net_addr),
    .eng_rdata  (eng_net_rdata)
  );

  gobou_core gobou_core_inst (
    .clk        (clk),
    .xrst       (xrst),
    .start      (start),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_in   (total_in),
    .total_out  (total_out),
    .bias_en    (bias_en),
    .relu_en    (relu_en),
    .busy       (busy),
    .done       (done),
    .img_we     (eng_img_we),
    .img_addr   (eng_img_addr),
    .img_wdata  (eng_img_wdata),
    .img_rdata  (eng_img_rdata),
    .net_addr   (eng_net_addr),
    .net_rdata  (eng_net_rdata)
  );

endmodule

//--- verification/ninjin_tb.sv
module ninjin_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_IN      = 4;
  localparam int N_OUT     = 3;
  localparam int IN_OFF    = 'h10;
  localparam int OUT_A     = 'h40;
  localparam int OUT_B     = 'h50;
  localparam int NET_OFF   = 'h20;
  localparam int BIAS_OFF  = NET_OFF + N_IN * N_OUT;
  localparam int MEM_BASE  = 'h80;
  localparam int MEM_WORDS = 8;
  // Average host access length with back-pressure
  localparam int OP_CYCLES = 5;
  localparam int LAYER_OPS = 35;
  localparam int EST_CYCLES = 10 + 12 * OP_CYCLES + 4 * MEM_WORDS * OP_CYCLES
                            + 2 * (LAYER_OPS * OP_CYCLES + N_OUT * (N_IN + 3))
                            + 6 * OP_CYCLES;
  localparam int TIMEOUT_CYCLES = 20 * EST_CYCLES;

  logic                          clk = 1'b0;
  logic                          xrst;
  logic                          cmd_valid;
  logic                          cmd_we;
  ninjin_pkg::host_addr_t        cmd_addr;
  logic [ninjin_pkg::BWIDTH-1:0] cmd_wdata;
  logic                          cmd_ready;
  logic                          rsp_valid;
  logic [ninjin_pkg::BWIDTH-1:0] rsp_data;
  logic                          rsp_ready;

  logic                          cmd_fire;
  logic                          rsp_fire;
  logic [ninjin_pkg::BWIDTH-1:0] rsp_cap;
  integer                        seed = 30931;
  int                            errors = 0;
  int                            cycles = 0;
  int                            img_model [0:255];
  int                            net_model [0:511];

  ninjin_top ninjin_top_inst (
    .clk       (clk),
    .xrst      (xrst),
    .cmd_valid (cmd_valid),
    .cmd_we    (cmd_we),
    .cmd_addr  (cmd_addr),
    .cmd_wdata (cmd_wdata),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .rsp_ready (rsp_ready)
  );

  always #50 clk = ~clk;

  always @(negedge clk) begin
    rsp_ready <= ($random(seed) & 3) != 0;
  end

  // Handshakes as seen just before each rising edge
  always @(posedge clk) begin
    cmd_fire <= cmd_valid && cmd_ready;
    rsp_fire <= rsp_valid && rsp_ready;
    if (rsp_valid && rsp_ready)
      rsp_cap <= rsp_data;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles before all tests finished", cycles);
      $display("Errors: %0d", errors);
      $display("** FAIL **");
      $finish;
    end
  end

  // ======================================================================
  // Protocol checks
  // ======================================================================
  a_rsp_stable: assert property (@(posedge clk) disable iff (!xrst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else begin
      errors++;
      $display("Response dropped or changed while rsp_ready was low");
    end

  a_rsp_latency: assert property (@(posedge clk) disable iff (!xrst)
    cmd_valid && cmd_ready && !cmd_we |=> rsp_valid)
    else begin
      errors++;
      $display("No response one cycle after an accepted read");
    end

  a_one_read: assert property (@(posedge clk) disable iff (!xrst)
    rsp_valid |-> !cmd_ready)
    else begin
      errors++;
      $display("Command port ready while a response was still pending");
    end

  a_img_held: assert property (@(posedge clk) disable iff (!xrst)
    cmd_valid && cmd_ready && cmd_addr.m.region == ninjin_pkg::REGION_IMG
    |-> !ninjin_top_inst.busy)
    else begin
      errors++;
      $display("Image access accepted while the engine was busy");
    end

  // ======================================================================
  // Host access
  // ======================================================================
  function automatic ninjin_pkg::host_addr_t reg_addr(input int index);
    ninjin_pkg::host_addr_t a;
    a.r.region = ninjin_pkg::REGION_REG;
    a.r.unused = '0;
    a.r.index  = 4'(index);
    return a;
  endfunction

  function automatic ninjin_pkg::host_addr_t mem_addr(input logic [1:0] region,
                                                      input int index);
    ninjin_pkg::host_addr_t a;
    a.m.region = region;
    a.m.index  = 14'(index);
    return a;
  endfunction

  function automatic int rand_small(input int lim);
    return $random(seed) % lim;
  endfunction

  // Called and returning on a falling edge
  task automatic host_write(input ninjin_pkg::host_addr_t addr, input logic [31:0] data);
    cmd_valid = 1'b1;
    cmd_we    = 1'b1;
    cmd_addr  = addr;
    cmd_wdata = data;
    do @(negedge clk); while (!cmd_fire);
    cmd_valid = 1'b0;
  endtask

  task automatic host_read(input ninjin_pkg::host_addr_t addr, output logic [31:0] data);
    cmd_valid = 1'b1;
    cmd_we    = 1'b0;
    cmd_addr  = addr;
    cmd_wdata = '0;
    do @(negedge clk); while (!cmd_fire);
    cmd_valid = 1'b0;
    while (!rsp_fire)
      @(negedge clk);
    data = rsp_cap;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp)
      else begin
        errors++;
        $display("** Error %s: expected %h, actual %h", name, exp, got);
      end
  endtask

  task automatic write_img(input int addr, input int val);
    host_write(mem_addr(ninjin_pkg::REGION_IMG, addr), 32'(val));
    img_model[addr] = val;
  endtask

  task automatic write_net(input int addr, input int val);
    host_write(mem_addr(ninjin_pkg::REGION_NET, addr), 32'(val));
    net_model[addr] = val;
  endtask

  // ======================================================================
  // Reference model
  // ======================================================================
  function automatic int model_out(input int o, input bit use_bias, input bit use_relu);
    int s;
    int i;
    s = 0;
    for (i = 0; i < N_IN; i++)
      s += img_model[IN_OFF + i] * net_model[NET_OFF + o * N_IN + i];
    s = s >>> ninjin_pkg::FRAC_BITS;
    if (use_bias)
      s += net_model[BIAS_OFF + o];
    if (use_relu && s < 0)
      s = 0;
    return s;
  endfunction

  // ======================================================================
  // Tests
  // ======================================================================
  task automatic check_registers;
    logic [31:0] wr_val [1:5];
    logic [31:0] got;
    int          idx;
    for (idx = 1; idx <= 5; idx++) begin
      wr_val[idx] = $random(seed);
      host_write(reg_addr(idx), wr_val[idx]);
    end
    host_write(reg_addr(ninjin_pkg::REG_CTRL), 32'hFFFF_FFFE);
    for (idx = 1; idx <= 5; idx++) begin
      host_read(reg_addr(idx), got);
      check_value($sformatf("register %0d readback", idx), wr_val[idx], got);
    end
    host_read(reg_addr(ninjin_pkg::REG_CTRL), got);
    check_value("ctrl readback", '0, got);
  endtask

  task automatic check_memories;
    logic [31:0] got;
    int          k;
    for (k = 0; k < MEM_WORDS; k++) begin
      write_img(MEM_BASE + k, $signed(16'($random(seed))));
      write_net(MEM_BASE + k, $signed(16'($random(seed))));
    end
    for (k = 0; k < MEM_WORDS; k++) begin
      host_read(mem_addr(ninjin_pkg::REGION_IMG, MEM_BASE + k), got);
      check_value($sformatf("image word %0h", MEM_BASE + k), img_model[MEM_BASE + k], got);
      host_read(mem_addr(ninjin_pkg::REGION_NET, MEM_BASE + k), got);
      check_value($sformatf("net word %0h", MEM_BASE + k), net_model[MEM_BASE + k], got);
    end
  endtask

  task automatic set_layer(input int out_off, input logic [31:0] flags);
    host_write(reg_addr(ninjin_pkg::REG_IN_OFFSET), IN_OFF);
    host_write(reg_addr(ninjin_pkg::REG_OUT_OFFSET), out_off);
    host_write(reg_addr(ninjin_pkg::REG_NET_OFFSET), NET_OFF);
    host_write(reg_addr(ninjin_pkg::REG_BASE), (N_OUT << 8) | N_IN);
    host_write(reg_addr(ninjin_pkg::REG_FLAGS), flags);
  endtask

  // Busy bit starts set so STATUS is read at least once
  task automatic wait_layer(output logic [31:0] status);
    status = 32'h2;
    while (status[1])
      host_read(reg_addr(ninjin_pkg::REG_STATUS), status);
  endtask

  task automatic check_outputs(input string name, input int out_off,
                               input bit use_bias, input bit use_relu);
    logic [31:0] got;
    int          o;
    for (o = 0; o < N_OUT; o++) begin
      host_read(mem_addr(ninjin_pkg::REGION_IMG, out_off + o), got);
      check_value($sformatf("%s output %0d", name, o), model_out(o, use_bias, use_relu), got);
    end
  endtask

  task automatic run_plain_layer;
    logic [31:0] st;
    int          k;
    for (k = 0; k < N_IN; k++)
      write_img(IN_OFF + k, rand_small(64));
    for (k = 0; k < N_IN * N_OUT; k++)
      write_net(NET_OFF + k, rand_small(512));
    for (k = 0; k < N_OUT; k++)
      write_net(BIAS_OFF + k, rand_small(128));
    set_layer(OUT_A, 32'h0);
    host_write(reg_addr(ninjin_pkg::REG_CTRL), 32'h1);
    wait_layer(st);
    check_value("plain layer status", 32'h1, st);
    check_outputs("plain layer", OUT_A, 1'b0, 1'b0);
  endtask

  task automatic run_bias_relu_layer;
    logic [31:0] st;
    logic [31:0] got;
    int          new_val;
    // Far below any shifted sum, so output 0 goes negative
    write_net(BIAS_OFF, -1000);
    set_layer(OUT_B, 32'hC000_0000);
    host_write(reg_addr(ninjin_pkg::REG_CTRL), 32'h1);
    host_read(reg_addr(ninjin_pkg::REG_STATUS), st);
    check_value("status during run", 32'h2, st);
    new_val = img_model[IN_OFF + 1] + 33;
    host_write(mem_addr(ninjin_pkg::REGION_IMG, IN_OFF + 1), 32'(new_val));
    host_read(reg_addr(ninjin_pkg::REG_STATUS), st);
    check_value("status after held write", 32'h1, st);
    check_outputs("bias relu layer", OUT_B, 1'b1, 1'b1);
    img_model[IN_OFF + 1] = new_val;
    host_read(mem_addr(ninjin_pkg::REGION_IMG, IN_OFF + 1), got);
    check_value("held image write", 32'(new_val), got);
  endtask

  // Index low bits alias REG_IN_OFFSET and the loaded test words
  task automatic check_none_region;
    logic [31:0] got;
    host_write(mem_addr(ninjin_pkg::REGION_NONE, MEM_BASE + 1), 32'h0000_7E57);
    host_read(mem_addr(ninjin_pkg::REGION_NONE, MEM_BASE + 1), got);
    check_value("none region read", '0, got);
    host_read(reg_addr(ninjin_pkg::REG_IN_OFFSET), got);
    check_value("none write vs register", IN_OFF, got);
    host_read(mem_addr(ninjin_pkg::REGION_IMG, MEM_BASE + 1), got);
    check_value("none write vs image", img_model[MEM_BASE + 1], got);
    host_read(mem_addr(ninjin_pkg::REGION_NET, MEM_BASE + 1), got);
    check_value("none write vs net", net_model[MEM_BASE + 1], got);
  endtask

  initial begin
    xrst      = 1'b0;
    cmd_valid = 1'b0;
    cmd_we    = 1'b0;
    cmd_addr  = '0;
    cmd_wdata = '0;
    rsp_ready = 1'b0;
    cmd_fire  = 1'b0;
    rsp_fire  = 1'b0;
    rsp_cap   = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;

    check_registers;
    check_memories;
    run_plain_layer;
    run_bias_relu_layer;
    check_none_region;

    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- vlog.f
hdl/ninjin_pkg.sv
hdl/ninjin_host_bridge.sv
hdl/ninjin_regs.sv
hdl/ninjin_img_buf.sv
hdl/gobou_net_mem.sv
hdl/gobou_core.sv
hdl/ninjin_top.sv
verification/ninjin_tb.sv
